// File: hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	localparam int fb_addr_w      = 8;   // 256 halfwords
	localparam int pix_w          = 16;  // rgb565
	localparam int cmd_w          = 8;
	localparam int frame_pixels   = 32;  // addresses 0 to 31
	localparam int pix_fifo_depth = 4;   // also the initial credit count

	typedef logic [fb_addr_w-1:0] fb_addr_t;
	typedef logic [pix_w-1:0]     pixel_t;
	typedef logic [cmd_w-1:0]     cmd_t;

	// framebuffer masters, as seen by the arbiter
	typedef enum logic {
		host = 1'b0,
		scan = 1'b1
	} master_t;

endpackage

`default_nettype wire

// File: hw/fb_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fb_mem_if;
	import lcd_pkg::*;

	logic     req;     // held until gnt
	logic     we;
	fb_addr_t addr;
	pixel_t   wdata;
	logic     gnt;     // acceptance when high with req at a rising edge
	pixel_t   rdata;
	logic     rvalid;  // one cycle after a read is accepted

	modport master (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata,
		input  rvalid
	);

	modport slave (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

`default_nettype wire

// File: hw/fb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
	input  wire      clk_sys,
	input  wire      lcd_cs,
	fb_mem_if.slave  host_bus,
	fb_mem_if.slave  scan_bus,
	fb_mem_if.master ram_bus
);
	import lcd_pkg::*;

	master_t last_win;  // winner of the last accepted request
	master_t rd_owner;  // master whose read data is due next
	master_t pick;
	logic    accept;

	always_comb begin
		if (host_bus.req && scan_bus.req)
			pick = (last_win == host) ? scan : host;  // loser of last round goes first
		else if (scan_bus.req)
			pick = scan;
		else
			pick = host;
	end

	assign ram_bus.req   = host_bus.req | scan_bus.req;
	assign ram_bus.we    = (pick == scan) ? scan_bus.we    : host_bus.we;
	assign ram_bus.addr  = (pick == scan) ? scan_bus.addr  : host_bus.addr;
	assign ram_bus.wdata = (pick == scan) ? scan_bus.wdata : host_bus.wdata;

	assign accept = ram_bus.req && ram_bus.gnt;

	assign host_bus.gnt = accept && (pick == host);
	assign scan_bus.gnt = accept && (pick == scan);

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			last_win <= scan;  // host takes the first tie
			rd_owner <= host;
		end else if (accept) begin
			last_win <= pick;
			if (!ram_bus.we)
				rd_owner <= pick;  // tag the read in flight
		end
	end

	// response goes back to the owner only
	assign host_bus.rvalid = ram_bus.rvalid && (rd_owner == host);
	assign scan_bus.rvalid = ram_bus.rvalid && (rd_owner == scan);
	assign host_bus.rdata  = (rd_owner == host) ? ram_bus.rdata : '0;
	assign scan_bus.rdata  = (rd_owner == scan) ? ram_bus.rdata : '0;

endmodule

`default_nettype wire

// File: hw/fb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fb_ram (
	input  wire     clk_sys,
	fb_mem_if.slave ram_bus
);
	import lcd_pkg::*;

	pixel_t mem [0:(1 << fb_addr_w) - 1];
	logic   wr_accept;
	logic   rd_accept;

	assign ram_bus.gnt = ram_bus.req;  // single port, never stalls

	assign wr_accept = ram_bus.req && ram_bus.gnt && ram_bus.we;
	assign rd_accept = ram_bus.req && ram_bus.gnt && !ram_bus.we;

	always_ff @(posedge clk_sys) begin
		if (wr_accept)
			mem[ram_bus.addr] <= ram_bus.wdata;
		if (rd_accept)
			ram_bus.rdata <= mem[ram_bus.addr];  // registered read
	end

	always_ff @(posedge clk_sys) begin
		ram_bus.rvalid <= rd_accept;  // single cycle pulse per read
	end

endmodule

`default_nettype wire

// File: hw/scanout_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module scanout_fetch (
	input  wire                  clk_sys,
	input  wire                  lcd_cs,
	input  wire                  frame_start,
	input  wire lcd_pkg::cmd_t   cmd_in,
	fb_mem_if.master             scan_bus,
	output logic                 pix_valid,
	output lcd_pkg::pixel_t      pix_data,
	input  wire                  credit_ret,
	output logic                 cmd_valid,
	output lcd_pkg::cmd_t        cmd_byte
);
	import lcd_pkg::*;

	typedef logic [$clog2(pix_fifo_depth + 1) - 1:0] credit_t;
	typedef logic [$clog2(2 * pix_w + 1) - 1:0]      drain_t;

	fb_addr_t rd_addr;    // next pixel, doubles as read count
	credit_t  credits;
	drain_t   drain_cnt;  // serializer still shifting the last pixel
	logic     active;
	logic     idle;
	logic     reads_done;
	logic     accept;
	logic     last_ret;

	assign idle       = !active && (drain_cnt == '0);
	assign reads_done = (rd_addr == fb_addr_t'(frame_pixels));

	// start request goes straight to the serializer
	assign cmd_valid = frame_start && idle;
	assign cmd_byte  = cmd_in;

	assign scan_bus.req   = active && !reads_done && (credits != '0);
	assign scan_bus.we    = 1'b0;  // read only master
	assign scan_bus.addr  = rd_addr;
	assign scan_bus.wdata = '0;

	assign accept = scan_bus.req && scan_bus.gnt;

	// final credit back means the last pixel just entered the shifter
	assign last_ret = credit_ret && reads_done &&
		(credits == credit_t'(pix_fifo_depth - 1));

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			active    <= 1'b0;
			rd_addr   <= '0;
			credits   <= credit_t'(pix_fifo_depth);
			drain_cnt <= '0;
		end else begin
			if (cmd_valid) begin
				active  <= 1'b1;
				rd_addr <= '0;
			end else if (accept) begin
				rd_addr <= rd_addr + 1'b1;
			end

			case ({accept, credit_ret})
				2'b10:   credits <= credits - 1'b1;  // read issued
				2'b01:   credits <= credits + 1'b1;  // pixel left the queue
				default: credits <= credits;
			endcase

			if (last_ret) begin
				active    <= 1'b0;
				drain_cnt <= drain_t'(2 * pix_w);  // two clocks per bit
			end else if (drain_cnt != '0) begin
				drain_cnt <= drain_cnt - 1'b1;
			end
		end
	end

	// one queue beat per read response
	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs)
			pix_valid <= 1'b0;
		else
			pix_valid <= scan_bus.rvalid;
	end

	always_ff @(posedge clk_sys) begin
		pix_data <= scan_bus.rdata;
	end

endmodule

`default_nettype wire

// File: hw/lcd_spi_tx.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_tx (
	input  wire                  clk_sys,
	input  wire                  lcd_cs,
	input  wire                  cmd_valid,
	input  wire lcd_pkg::cmd_t   cmd_byte,
	input  wire                  pix_valid,
	input  wire lcd_pkg::pixel_t pix_data,
	output logic                 credit_ret,
	output logic                 frame_busy,
	output logic                 lcd_sel,
	output logic                 lcd_dc,
	output logic                 lcd_sck,
	output logic                 lcd_mosi
);
	import lcd_pkg::*;

	typedef logic [$clog2(pix_fifo_depth) - 1:0]     ptr_t;
	typedef logic [$clog2(pix_fifo_depth + 1) - 1:0] fill_t;
	typedef logic [$clog2(pix_w + 1) - 1:0]          bit_cnt_t;
	typedef logic [$clog2(frame_pixels + 1) - 1:0]   pix_cnt_t;

	pixel_t   fifo_mem [pix_fifo_depth];
	ptr_t     wr_ptr;
	ptr_t     rd_ptr;
	fill_t    fifo_cnt;
	pixel_t   shreg;
	bit_cnt_t bits_left;  // bits of the current word not yet on mosi
	pix_cnt_t pix_left;   // pixels still to pop this frame
	logic     hold;       // bit on mosi, high phase still to come
	logic     step;
	logic     pop;

	assign step = frame_busy && !hold;
	assign pop  = step && (bits_left == '0) && (pix_left != '0) && (fifo_cnt != '0);

	assign credit_ret = pop;

	// pixel queue, never overflows under the credit limit
	always_ff @(posedge clk_sys) begin
		if (pix_valid)
			fifo_mem[wr_ptr] <= pix_data;
	end

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (pix_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({pix_valid, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			frame_busy <= 1'b0;
			lcd_sel    <= 1'b1;
			lcd_dc     <= 1'b0;
			lcd_sck    <= 1'b0;
			lcd_mosi   <= 1'b0;
			hold       <= 1'b0;
			bits_left  <= '0;
			pix_left   <= '0;
		end else if (!frame_busy) begin
			if (cmd_valid) begin
				frame_busy <= 1'b1;
				bits_left  <= bit_cnt_t'(cmd_w);
				pix_left   <= pix_cnt_t'(frame_pixels);
			end
		end else if (hold) begin
			lcd_sck <= 1'b1;  // receiver samples on this edge
			hold    <= 1'b0;
		end else begin
			lcd_sck <= 1'b0;
			if (bits_left != '0) begin
				lcd_mosi  <= shreg[pix_w-1];  // msb first
				lcd_sel   <= 1'b0;
				bits_left <= bits_left - 1'b1;
				hold      <= 1'b1;
			end else if (pix_left == '0) begin
				frame_busy <= 1'b0;  // last high phase just ended
				lcd_sel    <= 1'b1;
				lcd_dc     <= 1'b0;
				lcd_mosi   <= 1'b0;
			end else if (pop) begin
				lcd_mosi  <= fifo_mem[rd_ptr][pix_w-1];
				lcd_dc    <= 1'b1;  // data from here on
				bits_left <= bit_cnt_t'(pix_w - 1);
				pix_left  <= pix_left - 1'b1;
				hold      <= 1'b1;
			end
			// queue empty: sck stays low, frame stretches
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!frame_busy && cmd_valid)
			shreg <= {cmd_byte, {(pix_w - cmd_w){1'b0}}};  // command left aligned
		else if (step && (bits_left != '0))
			shreg <= shreg << 1;
		else if (pop)
			shreg <= fifo_mem[rd_ptr] << 1;  // msb already on mosi
	end

endmodule

`default_nettype wire

// File: hw/lcd_scan_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_scan_top (
	input  wire                    clk_sys,
	input  wire                    lcd_cs,
	input  wire                    host_req,
	input  wire                    host_we,
	input  wire lcd_pkg::fb_addr_t host_addr,
	input  wire lcd_pkg::pixel_t   host_wdata,
	input  wire                    frame_start,
	input  wire lcd_pkg::cmd_t     cmd_in,
	output logic                   host_gnt,
	output lcd_pkg::pixel_t        host_rdata,
	output logic                   host_rvalid,
	output logic                   frame_busy,
	output logic                   lcd_sel,
	output logic                   lcd_dc,
	output logic                   lcd_sck,
	output logic                   lcd_mosi
);
	import lcd_pkg::*;

	logic   cmd_valid;
	cmd_t   cmd_byte;
	logic   pix_valid;
	pixel_t pix_data;
	logic   credit_ret;

	fb_mem_if host_bus ();
	fb_mem_if scan_bus ();
	fb_mem_if ram_bus ();

	// host pins onto the host master bus
	assign host_bus.req   = host_req;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;

	assign host_gnt    = host_bus.gnt;  // end of host wait
	assign host_rdata  = host_bus.rdata;
	assign host_rvalid = host_bus.rvalid;

	fb_arbiter i_arbiter (
		.clk_sys  (clk_sys),
		.lcd_cs   (lcd_cs),
		.host_bus (host_bus.slave),
		.scan_bus (scan_bus.slave),
		.ram_bus  (ram_bus.master)
	);

	fb_ram i_ram (
		.clk_sys (clk_sys),
		.ram_bus (ram_bus.slave)
	);

	scanout_fetch i_fetch (
		.clk_sys     (clk_sys),
		.lcd_cs      (lcd_cs),
		.frame_start (frame_start),
		.cmd_in      (cmd_in),
		.scan_bus    (scan_bus.master),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.credit_ret  (credit_ret),
		.cmd_valid   (cmd_valid),
		.cmd_byte    (cmd_byte)
	);

	lcd_spi_tx i_spi_tx (
		.clk_sys    (clk_sys),
		.lcd_cs     (lcd_cs),
		.cmd_valid  (cmd_valid),
		.cmd_byte   (cmd_byte),
		.pix_valid  (pix_valid),
		.pix_data   (pix_data),
		.credit_ret (credit_ret),
		.frame_busy (frame_busy),
		.lcd_sel    (lcd_sel),
		.lcd_dc     (lcd_dc),
		.lcd_sck    (lcd_sck),
		.lcd_mosi   (lcd_mosi)
	);

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk_sys,
	output logic lcd_cs
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;  // 20 ns period
	end

	initial begin
		lcd_cs = 1'b1;
		repeat (3) @(posedge clk_sys);
		lcd_cs <= 1'b0;  // released after three cycles
	end

endmodule

`default_nettype wire

// File: tests/tb_lcd_scan.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_scan;
	import lcd_pkg::*;

	// one frame is the command plus every pixel bit at two clocks per bit
	localparam int unsigned frame_cycles   = 2 * (cmd_w + frame_pixels * pix_w) + 64;
	localparam int unsigned host_ops       = 256;
	localparam int unsigned timeout_cycles = 2 * (3 * frame_cycles + 6 * host_ops);

	logic     clk_sys;
	logic     lcd_cs;
	logic     host_req;
	logic     host_we;
	fb_addr_t host_addr;
	pixel_t   host_wdata;
	logic     frame_start;
	cmd_t     cmd_in;
	logic     host_gnt;
	pixel_t   host_rdata;
	logic     host_rvalid;
	logic     frame_busy;
	logic     lcd_sel;
	logic     lcd_dc;
	logic     lcd_sck;
	logic     lcd_mosi;

	pixel_t      model_fb [0:(1 << fb_addr_w) - 1];
	logic [1:0]  sck_bits [$];  // {dc, mosi} per sck rise
	int unsigned cycle_cnt = 0;
	int          err_cnt = 0;

	tb_clkgen i_clkgen (
		.clk_sys (clk_sys),
		.lcd_cs  (lcd_cs)
	);

	lcd_scan_top i_dut (
		.clk_sys     (clk_sys),
		.lcd_cs      (lcd_cs),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.frame_start (frame_start),
		.cmd_in      (cmd_in),
		.host_gnt    (host_gnt),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.frame_busy  (frame_busy),
		.lcd_sel     (lcd_sel),
		.lcd_dc      (lcd_dc),
		.lcd_sck     (lcd_sck),
		.lcd_mosi    (lcd_mosi)
	);

	task automatic abort_run(input string why);
		err_cnt++;
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("MISMATCH %s expected %0h actual %0h", test, expected, actual));
	endtask

	task automatic require(input logic cond, input string why);
		assert (cond === 1'b1) else
			abort_run(why);
	endtask

	// receiver on the lcd side samples on the rising sck edge
	always @(posedge lcd_sck) begin
		if (!lcd_sel)
			sck_bits.push_back({lcd_dc, lcd_mosi});
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles)
			abort_run($sformatf("timeout, run passed %0d cycles", timeout_cycles));
	end

	// one request held until granted with read data on the next cycle
	task automatic host_access(input logic we, input fb_addr_t addr, input pixel_t wdata,
			output pixel_t rdata);
		@(posedge clk_sys);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= addr;
		host_wdata <= wdata;
		@(negedge clk_sys);
		while (!host_gnt)
			@(negedge clk_sys);
		if (!we)
			require(!host_rvalid, "host_rvalid was high before the read was granted");
		@(posedge clk_sys);  // acceptance edge
		host_req <= 1'b0;
		rdata = '0;
		if (!we) begin
			@(negedge clk_sys);
			require(host_rvalid, "host_rvalid did not follow host_gnt by one cycle");
			rdata = host_rdata;
		end
	endtask

	task automatic write_word(input fb_addr_t addr, input pixel_t data);
		pixel_t unused;
		host_access(1'b1, addr, data, unused);
		model_fb[addr] = data;
	endtask

	task automatic read_back(input string test, input fb_addr_t addr);
		pixel_t data;
		host_access(1'b0, addr, '0, data);
		compare_value($sformatf("%s addr %0h", test, addr), 32'(model_fb[addr]), 32'(data));
	endtask

	task automatic fill_frame;
		for (int a = 0; a < frame_pixels; a++)
			write_word(fb_addr_t'(a), pixel_t'($urandom()));
	endtask

	task automatic start_frame(input cmd_t cmd);
		sck_bits.delete();
		@(posedge clk_sys);
		frame_start <= 1'b1;
		cmd_in      <= cmd;
		@(posedge clk_sys);
		frame_start <= 1'b0;
		@(negedge clk_sys);
		require(frame_busy, "frame_busy did not rise after frame_start");
	endtask

	task automatic await_frame_end;
		@(negedge clk_sys);
		while (frame_busy)
			@(negedge clk_sys);
		require(lcd_sel, "lcd_sel still low after frame_busy fell");
	endtask

	// command msb first with dc low and then each pixel msb first with dc high
	task automatic decode_frame(input string test, input cmd_t cmd);
		cmd_t   got_cmd;
		pixel_t word;
		int     idx;
		compare_value({test, " bit count"}, cmd_w + frame_pixels * pix_w, sck_bits.size());
		got_cmd = '0;
		for (int i = 0; i < cmd_w; i++) begin
			compare_value($sformatf("%s command dc bit %0d", test, i), 0,
				32'(sck_bits[i][1]));
			got_cmd = {got_cmd[cmd_w-2:0], sck_bits[i][0]};
		end
		compare_value({test, " command"}, 32'(cmd), 32'(got_cmd));
		idx = cmd_w;
		for (int p = 0; p < frame_pixels; p++) begin
			word = '0;
			for (int b = 0; b < pix_w; b++) begin
				compare_value($sformatf("%s pixel %0d dc bit %0d", test, p, b), 1,
					32'(sck_bits[idx][1]));
				word = {word[pix_w-2:0], sck_bits[idx][0]};
				idx++;
			end
			compare_value($sformatf("%s pixel %0d", test, p), 32'(model_fb[p]), 32'(word));
		end
	endtask

	task automatic reset_state;
		@(negedge clk_sys);
		compare_value("reset_state lcd_sel", 1, 32'(lcd_sel));
		compare_value("reset_state frame_busy", 0, 32'(frame_busy));
		compare_value("reset_state lcd_sck", 0, 32'(lcd_sck));
		compare_value("reset_state lcd_dc", 0, 32'(lcd_dc));
		compare_value("reset_state lcd_mosi", 0, 32'(lcd_mosi));
		compare_value("reset_state host_gnt", 0, 32'(host_gnt));
		compare_value("reset_state host_rvalid", 0, 32'(host_rvalid));
	endtask

	task automatic host_rw;
		for (int a = 0; a < 64; a++)
			write_word(fb_addr_t'(a), pixel_t'($urandom()));
		for (int a = 0; a < 64; a++)
			read_back("host_rw", fb_addr_t'(a));
	endtask

	task automatic frame_out;
		fill_frame();
		start_frame(8'h2C);
		await_frame_end();
		decode_frame("frame_out", 8'h2C);
	endtask

	task automatic host_during_scan;
		fb_addr_t addrs [16];
		start_frame(8'h3C);
		for (int i = 0; i < 16; i++) begin
			addrs[i] = fb_addr_t'(128 + ($urandom() % 128));  // upper half only
			write_word(addrs[i], pixel_t'($urandom()));
		end
		for (int i = 0; i < 16; i++)
			read_back("host_during_scan", addrs[i]);
		require(frame_busy, "host traffic did not overlap the frame");
		await_frame_end();
		decode_frame("host_during_scan", 8'h3C);
	endtask

	task automatic back_to_back;
		int unsigned bits_seen;
		fill_frame();
		start_frame(8'h2A);
		repeat (100) @(posedge clk_sys);
		frame_start <= 1'b1;  // ignored while the frame is still busy
		cmd_in      <= 8'h99;
		@(posedge clk_sys);
		frame_start <= 1'b0;
		await_frame_end();
		decode_frame("back_to_back", 8'h2A);
		bits_seen = sck_bits.size();
		repeat (64) @(negedge clk_sys);
		require(!frame_busy, "an extra frame started after a frame_start while busy");
		compare_value("back_to_back extra bits", bits_seen, sck_bits.size());
	endtask

	initial begin
		host_req    = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		frame_start = 1'b0;
		cmd_in      = '0;
		void'($urandom(51));
		while (lcd_cs !== 1'b0)
			@(posedge clk_sys);
		reset_state();
		host_rw();
		frame_out();
		host_during_scan();
		back_to_back();
		if (err_cnt == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run("checks failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: lcd_scan.f
hw/lcd_pkg.sv
hw/fb_mem_if.sv
hw/fb_arbiter.sv
hw/fb_ram.sv
hw/scanout_fetch.sv
hw/lcd_spi_tx.sv
hw/lcd_scan_top.sv
tests/tb_clkgen.sv
tests/tb_lcd_scan.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
rm -f sim.log \
	&& verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lcd_scan -f lcd_scan.f -o tb_lcd_scan \
	&& ./obj_dir/tb_lcd_scan 2>&1 | tee sim.log
grep -q "NO ERRORS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
